// ==== rtl/cacheGeometryPkg.sv ====
package cacheGeometryPkg;

	localparam int numWays = 4;
	localparam int numSets = 16;
	localparam int lineBytes = 16;

	localparam int addressWidth = 32;
	localparam int byteWidth = 8;
	localparam int lineWidth = lineBytes * byteWidth;

	localparam int offsetWidth = $clog2(lineBytes);
	localparam int indexWidth = $clog2(numSets);
	localparam int haltTagWidth = 4;
	localparam int mainTagWidth = addressWidth - offsetWidth - indexWidth - haltTagWidth;

	// Address field positions, low to high
	localparam int offsetLsb = 0;
	localparam int indexLsb = offsetLsb + offsetWidth;
	localparam int haltTagLsb = indexLsb + indexWidth;
	localparam int mainTagLsb = haltTagLsb + haltTagWidth;

	typedef logic [addressWidth-1:0] addressT;
	typedef logic [offsetWidth-1:0] offsetT;
	typedef logic [indexWidth-1:0] indexT;
	typedef logic [haltTagWidth-1:0] haltTagT;
	typedef logic [mainTagWidth-1:0] mainTagT;
	typedef logic [byteWidth-1:0] byteT;
	typedef logic [lineWidth-1:0] lineT; // Byte k at bits 8k+7..8k
	typedef logic [numWays-1:0] wayMaskT;
	typedef logic [$clog2(numWays)-1:0] wayIdT;

	function automatic offsetT offsetOf(input addressT addr);
		return addr[offsetLsb +: offsetWidth];
	endfunction

	function automatic indexT indexOf(input addressT addr);
		return addr[indexLsb +: indexWidth];
	endfunction

	function automatic haltTagT haltTagOf(input addressT addr);
		return addr[haltTagLsb +: haltTagWidth];
	endfunction

	function automatic mainTagT mainTagOf(input addressT addr);
		return addr[mainTagLsb +: mainTagWidth];
	endfunction

endpackage

// ==== rtl/cacheReplacePkg.sv ====
package cacheReplacePkg;

	localparam int lfsrWidth = 8;

	typedef logic [lfsrWidth-1:0] lfsrT;

	localparam lfsrT lfsrSeed = 8'h01; // Value after reset
	localparam lfsrT lfsrTaps = 8'hB8; // x^8 + x^6 + x^5 + x^4 + 1

	// One step of the right-shifting Galois form
	function automatic lfsrT lfsrNext(input lfsrT state);
		lfsrT shifted;
		shifted = state >> 1;
		if (state[0])
		begin
			shifted = shifted ^ lfsrTaps;
		end
		return shifted;
	endfunction

endpackage

// ==== rtl/lineStore.sv ====
`timescale 1ns/1ns

module lineStore import cacheGeometryPkg::*; #(
	parameter type entryT = lineT
) (
	input logic clk,
	input logic writeEnable,
	input indexT writeIndex,
	input entryT writeEntry,
	input indexT readIndex,
	output entryT readEntry
);

	entryT entries [numSets];

	always_ff @(posedge clk)
	begin
		if (writeEnable)
		begin
			entries[writeIndex] <= writeEntry;
		end
	end

	assign readEntry = entries[readIndex]; // Combinational read

endmodule

// ==== rtl/cacheWay.sv ====
`timescale 1ns/1ns

module cacheWay import cacheGeometryPkg::*; (
	input logic clk,
	input logic reset,
	input addressT address,
	input logic write,
	input byteT writeByte,
	input logic lineWrite,
	input lineT fillData,
	output logic wayHit,
	output logic setValid,
	output byteT wayByte
);

	indexT setIndex;
	offsetT byteOffset;
	haltTagT addressHaltTag;
	mainTagT addressMainTag;

	haltTagT storedHaltTag;
	mainTagT storedMainTag;
	lineT storedLine;

	logic [numSets-1:0] validBits;
	logic haltMatch;
	logic mainMatch;
	logic writeHit;
	logic dataWrite;
	lineT mergedLine;
	lineT nextLine;

	assign setIndex = indexOf(address);
	assign byteOffset = offsetOf(address);
	assign addressHaltTag = haltTagOf(address);
	assign addressMainTag = mainTagOf(address);

	// One valid bit per set
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validBits <= '0;
		end
		else if (lineWrite)
		begin
			validBits[setIndex] <= 1'b1;
		end
	end

	assign setValid = validBits[setIndex];

	lineStore #(
		.entryT(haltTagT)
	) uHaltStore (
		.clk(clk),
		.writeEnable(lineWrite),
		.writeIndex(setIndex),
		.writeEntry(addressHaltTag),
		.readIndex(setIndex),
		.readEntry(storedHaltTag)
	);

	lineStore #(
		.entryT(mainTagT)
	) uMainStore (
		.clk(clk),
		.writeEnable(lineWrite),
		.writeIndex(setIndex),
		.writeEntry(addressMainTag),
		.readIndex(setIndex),
		.readEntry(storedMainTag)
	);

	lineStore #(
		.entryT(lineT)
	) uDataStore (
		.clk(clk),
		.writeEnable(dataWrite),
		.writeIndex(setIndex),
		.writeEntry(nextLine),
		.readIndex(setIndex),
		.readEntry(storedLine)
	);

	// The narrow halt compare decides first; the wide compare only counts behind it
	always_comb
	begin
		haltMatch = (storedHaltTag == addressHaltTag);
		if (haltMatch)
		begin
			mainMatch = (storedMainTag == addressMainTag);
		end
		else
		begin
			mainMatch = 1'b0; // Halted
		end
	end

	assign wayHit = setValid & haltMatch & mainMatch;

	assign wayByte = storedLine[byteOffset * byteWidth +: byteWidth];

	// Byte write into the resident line
	always_comb
	begin
		mergedLine = storedLine;
		mergedLine[byteOffset * byteWidth +: byteWidth] = writeByte;
	end

	assign writeHit = write & wayHit; // Write miss is dropped
	assign dataWrite = lineWrite | writeHit;
	assign nextLine = lineWrite ? fillData : mergedLine;

endmodule

// ==== rtl/victimSelect.sv ====
`timescale 1ns/1ns

module victimSelect import cacheGeometryPkg::*, cacheReplacePkg::*; (
	input logic clk,
	input logic reset,
	input logic fill,
	input wayMaskT wayHit,
	input wayMaskT wayValid,
	output wayMaskT fillWay
);

	lfsrT lfsr;
	wayIdT randomId;
	wayMaskT randomWay;
	wayMaskT firstInvalid;
	logic anyInvalid;

	// Steps once per fill cycle
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			lfsr <= lfsrSeed;
		end
		else if (fill)
		begin
			lfsr <= lfsrNext(lfsr);
		end
	end

	assign randomId = wayIdT'(lfsr); // Low bits only
	assign randomWay = wayMaskT'(1) << randomId;

	always_comb
	begin
		firstInvalid = '0;
		for (int w = numWays - 1; w >= 0; w--)
		begin
			if (!wayValid[w])
			begin
				firstInvalid = wayMaskT'(1) << w; // Lowest one wins
			end
		end
	end

	assign anyInvalid = |(~wayValid);

	always_comb
	begin
		if (!fill)
		begin
			fillWay = '0;
		end
		else if (wayHit != '0)
		begin
			fillWay = wayHit; // Refill in place
		end
		else if (anyInvalid)
		begin
			fillWay = firstInvalid;
		end
		else
		begin
			fillWay = randomWay;
		end
	end

endmodule

// ==== rtl/cacheTop.sv ====
`timescale 1ns/1ns

module cacheTop import cacheGeometryPkg::*; (
	input logic clk,
	input logic reset,
	input addressT address,
	input logic read,
	input logic write,
	input byteT writeByte,
	input logic fill,
	input lineT fillData,
	output logic hit,
	output byteT readData
);

	wayMaskT wayHit;
	wayMaskT wayValid;
	wayMaskT fillWay;
	byteT wayByte [numWays];
	byteT hitByte;

	for (genvar w = 0; w < numWays; w++)
	begin : gWay
		cacheWay uWay (
			.clk(clk),
			.reset(reset),
			.address(address),
			.write(write),
			.writeByte(writeByte),
			.lineWrite(fillWay[w]),
			.fillData(fillData),
			.wayHit(wayHit[w]),
			.setValid(wayValid[w]),
			.wayByte(wayByte[w])
		);
	end

	victimSelect uVictim (
		.clk(clk),
		.reset(reset),
		.fill(fill),
		.wayHit(wayHit),
		.wayValid(wayValid),
		.fillWay(fillWay)
	);

	assign hit = |wayHit;

	// At most one way hits
	always_comb
	begin
		hitByte = '0;
		for (int w = 0; w < numWays; w++)
		begin
			if (wayHit[w])
			begin
				hitByte = wayByte[w];
			end
		end
	end

	assign readData = (read && hit) ? hitByte : '0;

endmodule

// ==== test/cacheTop_checker.sv ====
`timescale 1ns/1ns

module cacheTopChecker import cacheGeometryPkg::*; (
	input logic clk,
	input logic reset,
	input logic read,
	input logic fill,
	input logic hit,
	input byteT readData,
	input wayMaskT wayHit,
	input wayMaskT fillWay
);

	int failCount = 0;

	wayHitOneHot: assert property (@(posedge clk) disable iff (reset) $onehot0(wayHit))
	else
	begin
		$error("More than one way hits the same address");
		failCount = failCount + 1;
	end

	fillWayOneHot: assert property (@(posedge clk) disable iff (reset) fill |-> $onehot(fillWay))
	else
	begin
		$error("Fill does not select exactly one way");
		failCount = failCount + 1;
	end

	readDataGated: assert property (@(posedge clk) disable iff (reset) !read |-> readData == '0)
	else
	begin
		$error("Read data is nonzero while read is low");
		failCount = failCount + 1;
	end

	// First cycle out of reset sees an empty cache
	missAfterReset: assert property (@(posedge clk) $fell(reset) |-> !hit)
	else
	begin
		$error("Hit reported right after reset");
		failCount = failCount + 1;
	end

endmodule

bind cacheTop cacheTopChecker uChecker (
	.clk(clk),
	.reset(reset),
	.read(read),
	.fill(fill),
	.hit(hit),
	.readData(readData),
	.wayHit(wayHit),
	.fillWay(fillWay)
);

// ==== test/cacheTb.sv ====
`timescale 1ns/1ns

module cacheTb import cacheGeometryPkg::*; ();

	localparam int clkPeriod = 20;
	localparam int driveDelay = 2;
	localparam int resetCycles = 4;
	localparam int t2Lines = 8;
	localparam indexT t3MissIndex = 4'd9;
	localparam indexT t4Index = 4'd12;

	// One idle cycle closes each test
	localparam int test1Cycles = 20 + 1;
	localparam int test2Cycles = t2Lines * (1 + lineBytes) + 1;
	localparam int test3Cycles = 1 + lineBytes + 2 + 1;
	localparam int test4Cycles = numWays * 2 + 2 + numWays + 1;
	localparam int test5Cycles = t2Lines * 2 + 1 + numWays + 1;
	localparam int stimulusCycles = resetCycles + test1Cycles + test2Cycles + test3Cycles
		+ test4Cycles + test5Cycles;

	typedef logic [addressWidth-offsetWidth-1:0] lineKeyT;

	logic clk;
	logic reset;
	addressT address;
	logic read;
	logic write;
	byteT writeByte;
	logic fill;
	lineT fillData;
	logic hit;
	byteT readData;

	integer seed;
	int errorCount;
	int testsPassed;
	int testsFailed;

	lineT modelLines [lineKeyT]; // Resident lines by line address

	logic checkPending;
	string checkName;
	logic expectHit;
	byteT expectData;

	addressT t2Addr [t2Lines];
	addressT t4Addr [numWays + 1];

	cacheTop u_dut (
		.clk(clk),
		.reset(reset),
		.address(address),
		.read(read),
		.write(write),
		.writeByte(writeByte),
		.fill(fill),
		.fillData(fillData),
		.hit(hit),
		.readData(readData)
	);

	always #(clkPeriod / 2) clk = ~clk;

	function automatic lineKeyT lineKey(input addressT addr);
		return addr[addressWidth-1:offsetWidth];
	endfunction

	function automatic addressT makeAddress(input mainTagT mainTag, input haltTagT haltTag,
		input indexT index, input offsetT offset);
		return {mainTag, haltTag, index, offset};
	endfunction

	function automatic lineT randomLine();
		lineT line;
		for (int i = 0; i < lineWidth / 32; i++)
		begin
			line[i*32 +: 32] = $random(seed);
		end
		return line;
	endfunction

	// Expected read data with read high, from the line model
	function automatic byteT expectByte(input addressT addr, output logic found);
		lineKeyT key;
		offsetT offset;
		lineT line;
		byteT result;
		key = lineKey(addr);
		offset = addr[offsetLsb +: offsetWidth];
		found = 1'b0;
		result = '0;
		if (modelLines.exists(key) != 0)
		begin
			found = 1'b1;
			line = modelLines[key];
			result = line[offset * byteWidth +: byteWidth];
		end
		return result;
	endfunction

	task automatic checkHit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("ERROR %s: hit expected %0b, actual %0b", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkByte(input string name, input byteT expected, input byteT actual);
		if (actual !== expected)
		begin
			$display("ERROR %s: readData expected %02h, actual %02h", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkCount(input string name, input int expected, input int actual);
		if (actual != expected)
		begin
			$display("ERROR %s: count expected %0d, actual %0d", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic waitDrive();
		@(posedge clk);
		#driveDelay;
	endtask

	task automatic driveIdle();
		waitDrive();
		read = 1'b0;
		write = 1'b0;
		fill = 1'b0;
	endtask

	task automatic fillLine(input addressT addr, input lineT data);
		waitDrive();
		address = addr;
		fillData = data;
		fill = 1'b1;
		read = 1'b0;
		write = 1'b0;
		modelLines[lineKey(addr)] = data; // Hit or not, the line ends up resident
	endtask

	task automatic storeByte(input addressT addr, input byteT value);
		lineKeyT key;
		offsetT offset;
		lineT line;
		key = lineKey(addr);
		offset = addr[offsetLsb +: offsetWidth];
		waitDrive();
		address = addr;
		writeByte = value;
		write = 1'b1;
		read = 1'b0;
		fill = 1'b0;
		if (modelLines.exists(key) != 0)
		begin
			line = modelLines[key];
			line[offset * byteWidth +: byteWidth] = value;
			modelLines[key] = line;
		end
	endtask

	task automatic readAndCompare(input string name, input addressT addr);
		logic modelHit;
		byteT modelByte;
		waitDrive();
		address = addr;
		read = 1'b1;
		write = 1'b0;
		fill = 1'b0;
		modelByte = expectByte(addr, modelHit);
		expectHit = modelHit;
		expectData = modelByte;
		checkName = name;
		checkPending = 1'b1;
	endtask

	task automatic probeHit(input addressT addr, output logic found);
		waitDrive();
		address = addr;
		read = 1'b1;
		write = 1'b0;
		fill = 1'b0;
		@(negedge clk);
		found = hit;
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		driveIdle();
		if (errorCount == errorsBefore)
		begin
			$display("%s: passed", name);
			testsPassed++;
		end
		else
		begin
			$display("%s: failed with %0d errors", name, errorCount - errorsBefore);
			testsFailed++;
		end
	endtask

	// Outputs settle long before the falling edge
	always @(negedge clk)
	begin
		if (checkPending)
		begin
			checkHit(checkName, expectHit, hit);
			checkByte(checkName, expectData, readData);
			checkPending = 1'b0;
		end
	end

	initial
	begin
		#(2 * stimulusCycles * clkPeriod);
		$display("Watchdog expired before the tests completed");
		$display("TB FAILED");
		$finish;
	end

	initial
	begin
		int errorsBefore;
		int survivors;
		logic probed;
		addressT target;
		logic dummy;
		mainTagT t4MainTag;
		seed = 32'h2179a709;
		clk = 1'b0;
		reset = 1'b1;
		address = '0;
		read = 1'b0;
		write = 1'b0;
		writeByte = '0;
		fill = 1'b0;
		fillData = '0;
		checkPending = 1'b0;
		errorCount = 0;
		testsPassed = 0;
		testsFailed = 0;
		repeat (resetCycles) @(posedge clk);
		#driveDelay;
		reset = 1'b0;

		errorsBefore = errorCount;
		for (int i = 0; i < 20; i++)
		begin
			readAndCompare("test1 reset miss", addressT'($random(seed)));
		end
		finishTest("test1 reset miss", errorsBefore);

		errorsBefore = errorCount;
		for (int i = 0; i < t2Lines; i++)
		begin
			t2Addr[i] = makeAddress(mainTagT'($random(seed)), haltTagT'($random(seed)),
				indexT'(i), '0);
			fillLine(t2Addr[i], randomLine());
		end
		for (int i = 0; i < t2Lines; i++)
		begin
			for (int k = 0; k < lineBytes; k++)
			begin
				readAndCompare("test2 fill read", t2Addr[i] + addressT'(k));
			end
		end
		finishTest("test2 fill read", errorsBefore);

		errorsBefore = errorCount;
		target = t2Addr[2] + addressT'(5);
		storeByte(target, expectByte(target, dummy) ^ 8'h5A); // Always differs from old
		for (int k = 0; k < lineBytes; k++)
		begin
			readAndCompare("test3 byte write", t2Addr[2] + addressT'(k));
		end
		target = makeAddress(mainTagT'($random(seed)), haltTagT'($random(seed)),
			t3MissIndex, 4'd3);
		storeByte(target, 8'hC3);
		readAndCompare("test3 write miss", target);
		finishTest("test3 byte write", errorsBefore);

		errorsBefore = errorCount;
		t4MainTag = mainTagT'($random(seed));
		for (int k = 0; k <= numWays; k++)
		begin
			t4Addr[k] = makeAddress(t4MainTag, haltTagT'(k), t4Index, '0);
		end
		for (int k = 0; k < numWays; k++)
		begin
			fillLine(t4Addr[k], randomLine());
		end
		for (int k = 0; k < numWays; k++)
		begin
			readAndCompare("test4 full set", t4Addr[k] + addressT'(k));
		end
		fillLine(t4Addr[numWays], randomLine());
		readAndCompare("test4 fifth line", t4Addr[numWays] + addressT'(7));
		survivors = 0;
		for (int k = 0; k < numWays; k++)
		begin
			probeHit(t4Addr[k], probed);
			if (probed)
			begin
				survivors++;
			end
			else
			begin
				modelLines.delete(lineKey(t4Addr[k])); // Victim drops out of the model
			end
		end
		checkCount("test4 eviction", numWays - 1, survivors);
		finishTest("test4 eviction", errorsBefore);

		errorsBefore = errorCount;
		for (int i = 0; i < t2Lines; i++)
		begin
			readAndCompare("test5 main tag differs", t2Addr[i] ^ (addressT'(1) << mainTagLsb));
			readAndCompare("test5 halt tag differs", t2Addr[i] ^ (addressT'(1) << haltTagLsb));
		end
		fillLine(t4Addr[numWays], randomLine()); // Resident, so no eviction
		for (int k = 0; k <= numWays; k++)
		begin
			if (modelLines.exists(lineKey(t4Addr[k])) != 0)
			begin
				readAndCompare("test5 refill", t4Addr[k] + addressT'(k + 3));
			end
		end
		finishTest("test5 halting and refill", errorsBefore);

		if (u_dut.uChecker.failCount != 0)
		begin
			$display("Bound assertions failed %0d times", u_dut.uChecker.failCount);
		end
		$display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
			testsPassed, testsFailed, errorCount);
		if (testsFailed == 0 && errorCount == 0 && u_dut.uChecker.failCount == 0)
		begin
			$display("TB PASSED");
		end
		else
		begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
rtl/cacheGeometryPkg.sv
rtl/cacheReplacePkg.sv
rtl/lineStore.sv
rtl/cacheWay.sv
rtl/victimSelect.sv
rtl/cacheTop.sv
test/cacheTop_checker.sv
test/cacheTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module cacheTb \
	-f compile.f \
	-Mdir obj_dir \
	-o cacheSim

# Keep running past assertion errors so the testbench reports them
./obj_dir/cacheSim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "^TB PASSED$" sim.log
then
	echo "Simulation passed"
	exit 0
fi

echo "Simulation failed, see sim.log"
exit 1
